// File: build.f
hw/game_pkg.sv
hw/board_pkg.sv
hw/lfsr_rand.sv
hw/round_timer.sv
hw/beep_gen.sv
hw/seg_scan.sv
hw/game_ctrl.sv
hw/game_top.sv
bench/game_checker.sv
bench/game_tb.sv

// File: bench/game_tb.sv
module game_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TICK_DIV     = 2;
    localparam int ROUND_TICKS  = 3;
    localparam int BEEP_CYCLES  = 12;
    localparam int SCAN_DIV     = 2;
    localparam int ROUND_CYCLES = TICK_DIV * ROUND_TICKS;
    localparam int SCAN_CYCLES  = 2 * board_pkg::DIGITS * SCAN_DIV + 2;

    logic        clk;
    logic        sw;
    logic        power;
    logic        restart;
    logic        guess_valid;
    logic [6:0]  guess;
    logic        guess_ready;
    logic [15:0] led;
    logic [7:0]  seg;
    logic [7:0]  dig;
    logic [7:0]  row;
    logic [7:0]  colg;
    logic [7:0]  colr;
    logic        beep;

    int seed;
    int errors;
    int errors_at_start;
    int tests;
    int failed_tests;
    int exp_level;
    bit disp_on;
    int shown_digit;
    int cur;
    int held;
    int toggles;
    logic        last_beep;
    logic [6:0]  early_guess;
    logic [15:0] held_led;

    game_top #(.TICK_DIV(TICK_DIV), .ROUND_TICKS(ROUND_TICKS),
               .BEEP_CYCLES(BEEP_CYCLES), .SCAN_DIV(SCAN_DIV)) u_dut
    (
        .clk (clk), .sw (sw), .power (power), .restart (restart),
        .guess_valid (guess_valid), .guess (guess), .guess_ready (guess_ready),
        .led (led), .seg (seg), .dig (dig), .row (row), .colg (colg),
        .colr (colr), .beep (beep)
    );

    always #10 clk = ~clk;

    // level n compares n + 4 bits
    function automatic logic [6:0] level_mask(input int level);
        return 7'((1 << (level + 4)) - 1);
    endfunction

    // next level after a judged guess, 4 means victory
    function automatic int expected_level(input int level, input logic [6:0] g,
                                          input logic [6:0] target);
        if (((g ^ target) & level_mask(level)) != 7'd0)
            return level;
        return level + 1;
    endfunction

    // -1 for a blank or unknown pattern
    function automatic int decode_digit(input logic [7:0] code);
        for (int d = 0; d < 10; d++)
            if (board_pkg::seg_code(4'(d)) == code)
                return d;
        return -1;
    endfunction

    function automatic int error_total();
        return errors + u_dut.u_ctrl.u_checker.fail_count;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("%0d tests run, %0d failed, %0d errors", tests, failed_tests + 1,
                 error_total());
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    task automatic begin_test();
        errors_at_start = error_total();
    endtask

    task automatic end_test(input string name);
        tests++;
        if (error_total() == errors_at_start)
            $display("test %0d %s: passed", tests, name);
        else
        begin
            failed_tests++;
            $display("test %0d %s: failed", tests, name);
        end
    endtask

    task automatic wait_ready(input int limit);
        int n;
        n = 0;
        while (guess_ready !== 1'b1)
        begin
            if (n == limit)
                stop_on_timeout("guess_ready did not rise at the end of the round");
            @(negedge clk);
            n++;
        end
    endtask

    // the compare process checks the digit while it is selected
    task automatic wait_digit0();
        int n;
        n = 0;
        @(negedge clk);
        while (dig[0] !== 1'b0)
        begin
            if (n == SCAN_CYCLES)
                stop_on_timeout("digit 0 was never selected");
            @(negedge clk);
            n++;
        end
        while (dig[0] !== 1'b1)
        begin
            if (n == SCAN_CYCLES)
                stop_on_timeout("digit 0 stayed selected");
            @(negedge clk);
            n++;
        end
    endtask

    task automatic play_round(input int level, input bit correct, output int nxt);
        logic [6:0] mask;
        logic [6:0] rnd;
        logic [6:0] g;
        mask = level_mask(level);
        rnd  = 7'($random(seed));
        if (correct)
            g = (led[6:0] & mask) | (rnd & ~mask);
        else
            g = ((led[6:0] ^ 7'(1 << ({$random(seed)} % (level + 4)))) & mask)
                | (rnd & ~mask);
        nxt = expected_level(level, g, led[6:0]);
        if (nxt != level)
            disp_on <= 1'b0;
        guess       = g;
        guess_valid = 1'b1;
        @(negedge clk);
        guess_valid = 1'b0;
        if (led !== 16'd0)
            report_mismatch($sformatf("led %h, guess was not taken", led));
        @(negedge clk);
        if (nxt == 4 && led !== 16'hffff)
            report_mismatch($sformatf("led %h in victory", led));
        if (nxt != 4 && ($isunknown(led) || (led & ~{9'd0, level_mask(nxt)}) != 16'd0))
            report_mismatch($sformatf("led %h wider than level %0d", led, nxt));
        @(negedge clk);
        exp_level <= (nxt == 4) ? 0 : nxt;
        disp_on   <= 1'b1;
    endtask

    task automatic climb_to_victory(input int from);
        int lvl;
        int nxt;
        lvl = from;
        while (lvl <= 3)
        begin
            wait_ready(ROUND_CYCLES + 4);
            play_round(lvl, 1'b1, nxt);
            lvl = nxt;
            if (lvl <= 3)
                wait_digit0();
        end
        if (led !== 16'hffff)
            report_mismatch($sformatf("led %h, victory not reached", led));
    endtask

    // display compare, sampled on the falling edge
    always @(negedge clk)
    begin
        if (disp_on && exp_level == 0 && dig !== 8'hff)
            report_mismatch($sformatf("digit select %b with no level", dig));
        else if (disp_on && exp_level != 0 && dig[0] === 1'b0)
        begin
            shown_digit = decode_digit(seg);
            if (shown_digit != exp_level)
                report_mismatch($sformatf("digit 0 shows %0d, expected %0d",
                                          shown_digit, exp_level));
        end
    end

    initial
    begin
        clk         = 1'b0;
        sw          = 1'b1;
        power       = 1'b0;
        restart     = 1'b0;
        guess_valid = 1'b0;
        guess       = 7'd0;
        disp_on     = 1'b0;
        exp_level   = 0;
        seed        = 32'hbd97_5958;
        errors      = 0;
        tests       = 0;
        failed_tests = 0;
        repeat (16) @(negedge clk);
        sw = 1'b0;

        begin_test();
        repeat (4)
        begin
            @(negedge clk);
            if (led !== 16'd0 || guess_ready !== 1'b0 || beep !== 1'b0 || dig !== 8'hff)
                report_mismatch($sformatf("idle outputs led %h ready %b beep %b dig %b",
                                          led, guess_ready, beep, dig));
            // matrix dark before any round
            if (row !== 8'hff || colg !== 8'h00 || colr !== 8'h00)
                report_mismatch($sformatf("matrix row %b colg %b colr %b after reset",
                                          row, colg, colr));
        end
        disp_on <= 1'b1;
        end_test("reset and idle");

        begin_test();
        power = 1'b1;
        repeat (3) @(negedge clk);
        // greeting, no round yet
        if (guess_ready !== 1'b0 || led !== 16'd0)
            report_mismatch("greet state outputs not quiet");
        restart = 1'b1;
        disp_on <= 1'b0;
        held = 0;
        while (guess_ready !== 1'b1)
        begin
            if (held == ROUND_CYCLES + 4)
                stop_on_timeout("first round never ended");
            @(negedge clk);
            held++;
            restart = 1'b0;
            // full bar right after the start
            if (held == 1 && (colg !== 8'((1 << ROUND_TICKS) - 1) || colr !== 8'h00))
                report_mismatch($sformatf("bar colg %b colr %b at round start", colg, colr));
        end
        if (held != ROUND_CYCLES)
            report_mismatch($sformatf("round took %0d cycles, expected %0d",
                                      held, ROUND_CYCLES));
        if ($isunknown(led) || (led >> 5) != 16'd0)
            report_mismatch($sformatf("led %h wider than 5 bits", led));
        // red rows once the count is out
        if (colr !== 8'hff || colg !== 8'h00 || $countones(~row) != 1)
            report_mismatch($sformatf("matrix row %b colg %b colr %b at round end",
                                      row, colg, colr));
        exp_level <= 1;
        disp_on   <= 1'b1;
        wait_digit0();
        end_test("start and round length");

        begin_test();
        climb_to_victory(1);
        end_test("correct guesses to victory");

        begin_test();
        restart = 1'b1;
        disp_on <= 1'b0;
        @(negedge clk);
        restart = 1'b0;
        @(negedge clk);
        exp_level <= 1;
        disp_on   <= 1'b1;
        wait_ready(ROUND_CYCLES + 4);
        play_round(1, 1'b0, cur);
        if (guess_ready !== 1'b0)
            report_mismatch("no new round after a wrong guess");
        toggles   = 0;
        last_beep = beep;
        repeat (BEEP_CYCLES)
        begin
            @(negedge clk);
            if (beep !== last_beep)
                toggles++;
            last_beep = beep;
        end
        if (toggles == 0)
            report_mismatch("beep did not toggle after a wrong guess");
        wait_digit0();
        end_test("wrong guess replays level");

        begin_test();
        wait_ready(ROUND_CYCLES + 4);
        play_round(1, 1'b1, cur);
        if (guess_ready !== 1'b0)
            report_mismatch("round already over when the early guess was raised");
        held_led    = led;
        early_guess = (led[6:0] & level_mask(cur)) | (7'($random(seed)) & ~level_mask(cur));
        guess       = early_guess;
        guess_valid = 1'b1;
        held = 0;
        while (guess_ready !== 1'b1)
        begin
            if (held == ROUND_CYCLES + 4)
                stop_on_timeout("guess_ready never rose while a guess was held");
            @(negedge clk);
            held++;
            if (guess_ready !== 1'b1 && led !== held_led)
                report_mismatch("held guess taken before guess_ready");
        end
        disp_on <= 1'b0;
        @(negedge clk);
        guess_valid = 1'b0;
        if (led !== 16'd0)
            report_mismatch("held guess not taken once guess_ready rose");
        repeat (2) @(negedge clk);
        cur = expected_level(cur, early_guess, held_led[6:0]);
        exp_level <= cur;
        disp_on   <= 1'b1;
        wait_digit0();
        end_test("guess held until ready");

        begin_test();
        restart = 1'b1;
        disp_on <= 1'b0;
        @(negedge clk);
        restart = 1'b0;
        @(negedge clk);
        exp_level <= 1;
        disp_on   <= 1'b1;
        if ((led >> 5) != 16'd0)
            report_mismatch($sformatf("led %h after restart", led));
        wait_digit0();
        climb_to_victory(1);
        power = 1'b0;
        disp_on <= 1'b0;
        @(negedge clk);
        if (led !== 16'd0 || guess_ready !== 1'b0)
            report_mismatch($sformatf("led %h after power off", led));
        @(negedge clk);
        exp_level <= 0;
        disp_on   <= 1'b1;
        repeat (SCAN_CYCLES) @(negedge clk);
        end_test("restart and power off");

        $display("%0d tests run, %0d failed, %0d errors", tests, failed_tests,
                 error_total());
        if (error_total() == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: bench/game_checker.sv
module game_checker
(
    input logic             clk,
    input logic             sw,
    input game_pkg::state_t state,
    input logic             guess_ready,
    input logic             miss
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // a guess can only be taken in a play state
    ready_in_play: assert property (@(posedge clk) disable iff (sw)
        guess_ready |->
            (state inside {game_pkg::play1, game_pkg::play2, game_pkg::play3}))
    else
    begin
        fail_count++;
        $error("guess_ready high outside a play state");
    end

    // single cycle beep trigger
    miss_pulse: assert property (@(posedge clk) disable iff (sw) miss |=> !miss)
    else
    begin
        fail_count++;
        $error("miss held longer than one cycle");
    end

    ready_in_reset: assert property (@(posedge clk) sw |-> !guess_ready)
    else
    begin
        fail_count++;
        $error("guess_ready high during reset");
    end

endmodule

bind game_ctrl game_checker u_checker
(
    .clk         (clk),
    .sw          (sw),
    .state       (state),
    .guess_ready (guess_ready),
    .miss        (miss)
);

// File: hw/game_top.sv
module game_top
#(
    parameter int TICK_DIV    = 50_000_000,
    parameter int ROUND_TICKS = 8,
    parameter int BEEP_CYCLES = 12_500_000,
    parameter int SCAN_DIV    = 50_000
)
(
    input  logic                          clk,
    input  logic                          sw,
    input  logic                          power,
    input  logic                          restart,
    input  logic                          guess_valid,
    input  logic [game_pkg::GUESS_W-1:0]  guess,
    output logic                          guess_ready,
    output logic [board_pkg::LED_W-1:0]   led,
    output logic [7:0]                    seg,
    output logic [board_pkg::DIGITS-1:0]  dig,
    output logic [board_pkg::MATRIX_N-1:0] row,
    output logic [board_pkg::MATRIX_N-1:0] colg,
    output logic [board_pkg::MATRIX_N-1:0] colr,
    output logic                          beep
);

    logic [game_pkg::GUESS_W-1:0] target;
    logic                         next_target;
    logic                         round_start;
    logic                         round_over;
    logic                         miss;
    logic [1:0]                   level;

    game_ctrl u_ctrl
    (
        .clk         (clk),
        .sw          (sw),
        .power       (power),
        .restart     (restart),
        .guess_valid (guess_valid),
        .guess       (guess),
        .guess_ready (guess_ready),
        .target      (target),
        .next_target (next_target),
        .round_start (round_start),
        .round_over  (round_over),
        .miss        (miss),
        .level       (level),
        .led         (led)
    );

    lfsr_rand u_rand
    (
        .clk     (clk),
        .sw      (sw),
        .capture (next_target),
        .target  (target)
    );

    // countdown bar on the matrix
    round_timer #(.TICK_DIV(TICK_DIV), .ROUND_TICKS(ROUND_TICKS)) u_timer
    (
        .clk   (clk),
        .sw    (sw),
        .start (round_start),
        .over  (round_over),
        .row   (row),
        .colg  (colg),
        .colr  (colr)
    );

    beep_gen #(.BEEP_CYCLES(BEEP_CYCLES)) u_beep
    (
        .clk     (clk),
        .sw      (sw),
        .trigger (miss),
        .beep    (beep)
    );

    seg_scan #(.SCAN_DIV(SCAN_DIV)) u_seg
    (
        .clk   (clk),
        .sw    (sw),
        .level (level),
        .seg   (seg),
        .dig   (dig)
    );

endmodule

// File: hw/game_ctrl.sv
module game_ctrl
(
    input  logic                         clk,
    input  logic                         sw,
    input  logic                         power,
    input  logic                         restart,
    input  logic                         guess_valid,
    input  logic [game_pkg::GUESS_W-1:0] guess,
    output logic                         guess_ready,
    input  logic [game_pkg::GUESS_W-1:0] target,
    output logic                         next_target,
    output logic                         round_start,
    input  logic                         round_over,
    output logic                         miss,
    output logic [1:0]                   level,
    output logic [board_pkg::LED_W-1:0]  led
);

    game_pkg::state_t             state;
    game_pkg::state_t             next_state;
    logic [game_pkg::GUESS_W-1:0] guess_q;
    logic [game_pkg::GUESS_W-1:0] mask;
    logic                         in_play;
    logic                         in_judge;
    logic                         match;
    logic                         accept;

    // play or judge state belonging to a level
    function automatic game_pkg::state_t level_state(input logic [1:0] lvl,
                                                     input logic       judge);
        game_pkg::state_t s;
        case (lvl)
            2'd1:    s = judge ? game_pkg::judge1 : game_pkg::play1;
            2'd2:    s = judge ? game_pkg::judge2 : game_pkg::play2;
            default: s = judge ? game_pkg::judge3 : game_pkg::play3;
        endcase
        return s;
    endfunction

    function automatic logic is_play(input game_pkg::state_t s);
        return s inside {game_pkg::play1, game_pkg::play2, game_pkg::play3};
    endfunction

    assign in_play  = is_play(state);
    assign in_judge = state inside {game_pkg::judge1, game_pkg::judge2, game_pkg::judge3};

    always_comb
    begin
        case (state)
            game_pkg::play1, game_pkg::judge1: level = 2'd1;
            game_pkg::play2, game_pkg::judge2: level = 2'd2;
            game_pkg::play3, game_pkg::judge3: level = 2'd3;
            default:                           level = 2'd0;
        endcase
    end

    // only the low level_width bits take part
    always_comb
    begin
        for (int i = 0; i < game_pkg::GUESS_W; i++)
            mask[i] = (i < game_pkg::level_width(level));
    end

    assign guess_ready = in_play && round_over;
    assign accept      = guess_valid && guess_ready;
    assign match       = ((guess_q ^ target) & mask) == '0;

    // guess is judged one cycle after it is taken
    always_ff @(posedge clk)
    begin
        if (accept)
            guess_q <= guess;
    end

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
            state <= game_pkg::idle;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        if (!power)
            next_state = game_pkg::idle;
        else
        begin
            case (state)
                game_pkg::idle:
                    next_state = game_pkg::greet;
                game_pkg::greet:
                    if (restart)
                        next_state = game_pkg::play1;
                game_pkg::play1, game_pkg::play2, game_pkg::play3:
                begin
                    if (accept)
                        next_state = level_state(level, 1'b1);
                    else if (restart && state != game_pkg::play1)
                        next_state = game_pkg::play1;
                end
                game_pkg::judge1, game_pkg::judge2, game_pkg::judge3:
                begin
                    if (!match)
                        next_state = level_state(level, 1'b0);
                    else if (int'(level) == game_pkg::NUM_LEVELS)
                        next_state = game_pkg::victory;
                    else
                        next_state = level_state(level + 2'd1, 1'b0);
                end
                game_pkg::victory:
                    if (restart)
                        next_state = game_pkg::play1;
                default:
                    next_state = game_pkg::idle;
            endcase
        end
    end

    // timer restarts whenever a play state is entered, also on a replay
    assign round_start = is_play(next_state) && (next_state != state);

    // new target at power up and after every judge
    assign next_target = in_judge || (state == game_pkg::idle && power);
    assign miss        = in_judge && power && !match;

    always_comb
    begin
        led = '0;
        if (in_play)
            led[game_pkg::GUESS_W-1:0] = target & mask;
        else if (state == game_pkg::victory)
            led = '1;
    end

endmodule

// File: hw/seg_scan.sv
module seg_scan
#(
    parameter int SCAN_DIV = 50_000
)
(
    input  logic                        clk,
    input  logic                        sw,
    input  logic [1:0]                  level,
    output logic [7:0]                  seg,
    output logic [board_pkg::DIGITS-1:0] dig
);

    localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam int IDX_W = $clog2(board_pkg::DIGITS);

    logic [DIV_W-1:0]            div_cnt;
    logic [IDX_W-1:0]            digit_idx;
    logic [board_pkg::DIGITS-1:0] one_hot;

    // dwell on each digit for SCAN_DIV cycles
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            div_cnt   <= '0;
            digit_idx <= '0;
        end
        else if (div_cnt == DIV_W'(SCAN_DIV - 1))
        begin
            div_cnt   <= '0;
            digit_idx <= digit_idx + 1'b1;
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

    always_comb
    begin
        one_hot            = '0;
        one_hot[digit_idx] = 1'b1;
    end

    // registered so seg and dig always change together
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            dig <= '1;
            seg <= board_pkg::SEG_BLANK;
        end
        else if (level == 2'd0)
        begin
            // no level, whole display off
            dig <= '1;
            seg <= board_pkg::SEG_BLANK;
        end
        else
        begin
            dig <= ~one_hot;
            seg <= (digit_idx == '0) ? board_pkg::seg_code({2'b00, level})
                                     : board_pkg::SEG_BLANK;
        end
    end

endmodule

// File: hw/beep_gen.sv
module beep_gen
#(
    parameter int BEEP_CYCLES = 12_500_000
)
(
    input  logic clk,
    input  logic sw,
    input  logic trigger,
    output logic beep
);

    localparam int DUR_W = $clog2(BEEP_CYCLES + 1);

    logic [DUR_W-1:0] dur_left;
    logic [1:0]       tone_div;
    logic             tone;

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            dur_left <= '0;
            tone_div <= '0;
            tone     <= 1'b0;
        end
        else if (trigger)
        begin
            // retrigger restarts the whole beep
            dur_left <= DUR_W'(BEEP_CYCLES);
            tone_div <= '0;
            tone     <= 1'b1;
        end
        else if (dur_left != '0)
        begin
            dur_left <= dur_left - 1'b1;
            tone_div <= tone_div + 1'b1;
            // flip every 4 cycles
            if (tone_div == 2'd3)
                tone <= ~tone;
        end
    end

    assign beep = tone && (dur_left != '0);

endmodule

// File: hw/round_timer.sv
module round_timer
#(
    parameter int TICK_DIV    = 50_000_000,
    parameter int ROUND_TICKS = 8
)
(
    input  logic                          clk,
    input  logic                          sw,
    input  logic                          start,
    output logic                          over,
    output logic [board_pkg::MATRIX_N-1:0] row,
    output logic [board_pkg::MATRIX_N-1:0] colg,
    output logic [board_pkg::MATRIX_N-1:0] colr
);

    localparam int DIV_W  = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam int TICK_W = $clog2(ROUND_TICKS + 1);
    localparam int ROW_W  = $clog2(board_pkg::MATRIX_N);

    // the loading edge already counts as the first cycle of the round
    localparam logic [DIV_W-1:0]  DIV_LOAD  = DIV_W'(1 % TICK_DIV);
    localparam logic [TICK_W-1:0] TICK_LOAD =
        TICK_W'((TICK_DIV == 1) ? ROUND_TICKS - 1 : ROUND_TICKS);

    logic              run;
    logic [DIV_W-1:0]  div_cnt;
    logic [TICK_W-1:0] ticks_left;
    logic [ROW_W-1:0]  row_idx;

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            run        <= 1'b0;
            div_cnt    <= '0;
            ticks_left <= '0;
        end
        else if (start)
        begin
            run        <= 1'b1;
            div_cnt    <= DIV_LOAD;
            ticks_left <= TICK_LOAD;
        end
        else if (ticks_left != '0)
        begin
            if (div_cnt == DIV_W'(TICK_DIV - 1))
            begin
                div_cnt    <= '0;
                ticks_left <= ticks_left - 1'b1;
            end
            else
                div_cnt <= div_cnt + 1'b1;
        end
    end

    // held until the next start
    assign over = run && (ticks_left == '0);

    // row select walks through the matrix every cycle
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
            row_idx <= '0;
        else
            row_idx <= row_idx + 1'b1;
    end

    // rows active low, columns active high
    always_comb
    begin
        row  = '1;
        colg = '0;
        colr = '0;
        if (run)
        begin
            row[row_idx] = 1'b0;
            if (over)
                colr = '1;
            else
            begin
                // one green column per remaining tick
                for (int c = 0; c < board_pkg::MATRIX_N; c++)
                    colg[c] = (c < ticks_left);
            end
        end
    end

endmodule

// File: hw/lfsr_rand.sv
module lfsr_rand
(
    input  logic                         clk,
    input  logic                         sw,
    input  logic                         capture,
    output logic [game_pkg::GUESS_W-1:0] target
);

    logic [15:0] lfsr;
    logic        feedback;

    // taps 16, 14, 13, 11 give the full 65535 state cycle
    assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    // free running, the player's timing supplies the randomness
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
            lfsr <= 16'hace1;
        else
            lfsr <= {lfsr[14:0], feedback};
    end

    always_ff @(posedge clk)
    begin
        if (capture)
            target <= lfsr[game_pkg::GUESS_W-1:0];
    end

endmodule

// File: hw/board_pkg.sv
package board_pkg;

    localparam int LED_W    = 16;
    localparam int DIGITS   = 8;
    localparam int MATRIX_N = 8;

    // all segments dark
    localparam logic [7:0] SEG_BLANK = 8'hff;

    // bit order {dp, g, f, e, d, c, b, a}, a low bit lights the segment
    function automatic logic [7:0] seg_code(input logic [3:0] digit);
        logic [7:0] code;
        case (digit)
            4'd0:    code = 8'hc0;
            4'd1:    code = 8'hf9;
            4'd2:    code = 8'ha4;
            4'd3:    code = 8'hb0;
            4'd4:    code = 8'h99;
            4'd5:    code = 8'h92;
            4'd6:    code = 8'h82;
            4'd7:    code = 8'hf8;
            4'd8:    code = 8'h80;
            4'd9:    code = 8'h90;
            default: code = SEG_BLANK;
        endcase
        return code;
    endfunction

endpackage

// File: hw/game_pkg.sv
package game_pkg;

    // one judge state follows every play state
    typedef enum logic [3:0]
    {
        idle,
        greet,
        play1,
        judge1,
        play2,
        judge2,
        play3,
        judge3,
        victory
    } state_t;

    localparam int GUESS_W    = 7;
    localparam int NUM_LEVELS = 3;

    // compare width grows by one bit per level
    function automatic int unsigned level_width(input logic [1:0] level);
        int unsigned w;
        case (level)
            2'd1:    w = 5;
            2'd2:    w = 6;
            default: w = GUESS_W;
        endcase
        return w;
    endfunction

endpackage
